/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := rvga_core_tb
FILELIST  := rvga_core.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := No errors

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/rvga_core.sv */
`timescale 1ns/1ps

module rvga_core
  import rvga_pkg::*;
  (
    input  logic     clk
  , input  logic     rst_i

  , input  rvga_word instr_i
  , input  logic     instr_v_i

  , output logic     wb_v_o
  , output rvga_reg  wb_rd_o
  , output rvga_word wb_data_o
  );

  rvga_reg     decode_rfetch_rs1;
  rvga_reg     decode_rfetch_rs2;
  rvga_reg     decode_rfetch_rd;
  logic        decode_rfetch_rd_w_v;
  rvga_word    decode_rfetch_imm_data;
  logic        decode_rfetch_imm_v;
  rvga_artop_e decode_rfetch_artop;
  logic        decode_rfetch_alt_art;

  rvga_reg     rfetch_execute_rs1;
  rvga_reg     rfetch_execute_rs2;
  rvga_reg     rfetch_execute_rd;
  logic        rfetch_execute_rd_w_v;
  rvga_word    rfetch_execute_imm_data;
  logic        rfetch_execute_imm_v;
  rvga_word    rfetch_execute_rs1_data;
  rvga_word    rfetch_execute_rs2_data;
  rvga_artop_e rfetch_execute_artop;
  logic        rfetch_execute_alt_art;

  logic        writeback_rfetch_rd_w_v;
  rvga_reg     writeback_rfetch_rd;
  rvga_word    writeback_rfetch_rd_data;

  rvga_decode u_decode (
    .clk        (clk)
  , .rst_i      (rst_i)
  , .instr_i    (instr_i)
  , .instr_v_i  (instr_v_i)
  , .rs1_o      (decode_rfetch_rs1)
  , .rs2_o      (decode_rfetch_rs2)
  , .rd_o       (decode_rfetch_rd)
  , .rd_w_v_o   (decode_rfetch_rd_w_v)
  , .imm_data_o (decode_rfetch_imm_data)
  , .imm_v_o    (decode_rfetch_imm_v)
  , .artop_o    (decode_rfetch_artop)
  , .alt_art_o  (decode_rfetch_alt_art)
  );

  rvga_rfetch_stage u_rfetch (
    .clk                        (clk)
  , .rst_i                      (rst_i)
  , .decode_rfetch_rs1_i        (decode_rfetch_rs1)
  , .decode_rfetch_rs2_i        (decode_rfetch_rs2)
  , .decode_rfetch_rd_i         (decode_rfetch_rd)
  , .decode_rfetch_rd_w_v_i     (decode_rfetch_rd_w_v)
  , .decode_rfetch_imm_data_i   (decode_rfetch_imm_data)
  , .decode_rfetch_imm_v_i      (decode_rfetch_imm_v)
  , .decode_rfetch_artop_i      (decode_rfetch_artop)
  , .decode_rfetch_alt_art_i    (decode_rfetch_alt_art)
  , .rfetch_execute_rs1_o       (rfetch_execute_rs1)
  , .rfetch_execute_rs2_o       (rfetch_execute_rs2)
  , .rfetch_execute_rd_o        (rfetch_execute_rd)
  , .rfetch_execute_rd_w_v_o    (rfetch_execute_rd_w_v)
  , .rfetch_execute_imm_data_o  (rfetch_execute_imm_data)
  , .rfetch_execute_imm_v_o     (rfetch_execute_imm_v)
  , .rfetch_execute_rs1_data_o  (rfetch_execute_rs1_data)
  , .rfetch_execute_rs2_data_o  (rfetch_execute_rs2_data)
  , .rfetch_execute_artop_o     (rfetch_execute_artop)
  , .rfetch_execute_alt_art_o   (rfetch_execute_alt_art)
  , .writeback_rfetch_rd_w_v_i  (writeback_rfetch_rd_w_v)
  , .writeback_rfetch_rd_i      (writeback_rfetch_rd)
  , .writeback_rfetch_rd_data_i (writeback_rfetch_rd_data)
  );

  rvga_execute u_execute (
    .clk                       (clk)
  , .rst_i                     (rst_i)
  , .rfetch_execute_rs1_i      (rfetch_execute_rs1)
  , .rfetch_execute_rs2_i      (rfetch_execute_rs2)
  , .rfetch_execute_rd_i       (rfetch_execute_rd)
  , .rfetch_execute_rd_w_v_i   (rfetch_execute_rd_w_v)
  , .rfetch_execute_imm_data_i (rfetch_execute_imm_data)
  , .rfetch_execute_imm_v_i    (rfetch_execute_imm_v)
  , .rfetch_execute_rs1_data_i (rfetch_execute_rs1_data)
  , .rfetch_execute_rs2_data_i (rfetch_execute_rs2_data)
  , .rfetch_execute_artop_i    (rfetch_execute_artop)
  , .rfetch_execute_alt_art_i  (rfetch_execute_alt_art)
  , .wb_rd_w_v_o               (writeback_rfetch_rd_w_v)
  , .wb_rd_o                   (writeback_rfetch_rd)
  , .wb_data_o                 (writeback_rfetch_rd_data)
  );

  // Result register doubles as the visible writeback
  assign wb_v_o    = writeback_rfetch_rd_w_v;
  assign wb_rd_o   = writeback_rfetch_rd;
  assign wb_data_o = writeback_rfetch_rd_data;

endmodule : rvga_core

/* hw/rvga_decode.sv */
`timescale 1ns/1ps

module rvga_decode
  import rvga_pkg::*;
  (
    input  logic        clk
  , input  logic        rst_i

  , input  rvga_word    instr_i
  , input  logic        instr_v_i

  , output rvga_reg     rs1_o
  , output rvga_reg     rs2_o
  , output rvga_reg     rd_o
  , output logic        rd_w_v_o
  , output rvga_word    imm_data_o
  , output logic        imm_v_o
  , output rvga_artop_e artop_o
  , output logic        alt_art_o
  );

  rvga_opc     opcode;
  rvga_funct3  funct3;
  rvga_artop_e artop;
  rvga_reg     rd;
  logic        is_op;
  logic        is_opimm;
  logic        rd_w_v;
  logic        alt_art;

  always_comb begin
    opcode   = rvga_opcode(instr_i);
    funct3   = rvga_f3(instr_i);
    artop    = rvga_artop_e'(funct3);
    rd       = rvga_rd(instr_i);
    is_op    = (opcode == RVGA_OPC_OP);
    is_opimm = (opcode == RVGA_OPC_OPIMM);

    // Only valid ALU ops that target a real register write back
    rd_w_v = instr_v_i && (is_op || is_opimm) && (rd != '0);

    // For OP-IMM bit 30 is immediate except on shift right
    if (is_op) begin
      alt_art = instr_i[RVGA_ALT_BIT];
    end else if (is_opimm && artop == RVGA_ARTOP_SRL) begin
      alt_art = instr_i[RVGA_ALT_BIT];
    end else begin
      alt_art = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rs1_o      <= '0;
      rs2_o      <= '0;
      rd_o       <= '0;
      rd_w_v_o   <= 1'b0;
      imm_data_o <= '0;
      imm_v_o    <= 1'b0;
      artop_o    <= RVGA_ARTOP_ADD;
      alt_art_o  <= 1'b0;
    end else begin
      rs1_o      <= rvga_rs1(instr_i);
      rs2_o      <= rvga_rs2(instr_i);
      rd_o       <= rd;
      rd_w_v_o   <= rd_w_v;
      imm_data_o <= rvga_imm_i(instr_i);
      imm_v_o    <= is_opimm; // Immediate replaces rs2
      artop_o    <= artop;
      alt_art_o  <= alt_art;
    end
  end

endmodule : rvga_decode

/* hw/rvga_execute.sv */
`timescale 1ns/1ps

module rvga_execute
  import rvga_pkg::*;
  (
    input  logic        clk
  , input  logic        rst_i

  , input  rvga_reg     rfetch_execute_rs1_i
  , input  rvga_reg     rfetch_execute_rs2_i
  , input  rvga_reg     rfetch_execute_rd_i
  , input  logic        rfetch_execute_rd_w_v_i
  , input  rvga_word    rfetch_execute_imm_data_i
  , input  logic        rfetch_execute_imm_v_i
  , input  rvga_word    rfetch_execute_rs1_data_i
  , input  rvga_word    rfetch_execute_rs2_data_i
  , input  rvga_artop_e rfetch_execute_artop_i
  , input  logic        rfetch_execute_alt_art_i

  , output logic        wb_rd_w_v_o
  , output rvga_reg     wb_rd_o
  , output rvga_word    wb_data_o
  );

  rvga_word   rs1_fwd;
  rvga_word   rs2_fwd;
  rvga_word   op_a;
  rvga_word   op_b;
  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;
  rvga_word   alu_result;

  // Forward from the result register, which the regfile only sees next edge
  always_comb begin
    rs1_fwd = rfetch_execute_rs1_data_i;
    if (wb_rd_w_v_o && wb_rd_o == rfetch_execute_rs1_i) begin
      rs1_fwd = wb_data_o;
    end

    rs2_fwd = rfetch_execute_rs2_data_i;
    if (wb_rd_w_v_o && wb_rd_o == rfetch_execute_rs2_i) begin
      rs2_fwd = wb_data_o;
    end

    op_a = rs1_fwd;
    op_b = rfetch_execute_imm_v_i ? rfetch_execute_imm_data_i : rs2_fwd;
  end

  always_comb begin
    shamt       = op_b[4:0];
    lt_signed   = $signed(op_a) < $signed(op_b);
    lt_unsigned = op_a < op_b;

    case (rfetch_execute_artop_i)
      RVGA_ARTOP_ADD: begin
        alu_result = rfetch_execute_alt_art_i ? op_a - op_b : op_a + op_b;
      end
      RVGA_ARTOP_SLL:  alu_result = op_a << shamt;
      RVGA_ARTOP_SLT:  alu_result = {31'b0, lt_signed};
      RVGA_ARTOP_SLTU: alu_result = {31'b0, lt_unsigned};
      RVGA_ARTOP_XOR:  alu_result = op_a ^ op_b;
      RVGA_ARTOP_SRL: begin
        if (rfetch_execute_alt_art_i) begin
          alu_result = rvga_word'($signed(op_a) >>> shamt); // sra
        end else begin
          alu_result = op_a >> shamt;
        end
      end
      RVGA_ARTOP_OR:   alu_result = op_a | op_b;
      RVGA_ARTOP_AND:  alu_result = op_a & op_b;
      default:         alu_result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wb_rd_w_v_o <= 1'b0;
      wb_rd_o     <= '0;
      wb_data_o   <= '0;
    end else begin
      wb_rd_w_v_o <= rfetch_execute_rd_w_v_i;
      wb_rd_o     <= rfetch_execute_rd_i;
      wb_data_o   <= alu_result;
    end
  end

endmodule : rvga_execute

/* hw/rvga_pkg.sv */
package rvga_pkg;

  typedef logic [31:0] rvga_word; // Data, immediates and instruction words
  typedef logic [4:0]  rvga_reg;  // Register index
  typedef logic [6:0]  rvga_opc;  // Major opcode field
  typedef logic [2:0]  rvga_funct3;

  // funct3 classes of the integer ALU
  typedef enum logic [2:0] {
    RVGA_ARTOP_ADD  = 3'b000,
    RVGA_ARTOP_SLL  = 3'b001,
    RVGA_ARTOP_SLT  = 3'b010,
    RVGA_ARTOP_SLTU = 3'b011,
    RVGA_ARTOP_XOR  = 3'b100,
    RVGA_ARTOP_SRL  = 3'b101,
    RVGA_ARTOP_OR   = 3'b110,
    RVGA_ARTOP_AND  = 3'b111
  } rvga_artop_e;

  localparam rvga_opc RVGA_OPC_OP    = 7'b0110011;
  localparam rvga_opc RVGA_OPC_OPIMM = 7'b0010011;

  localparam int RVGA_ALT_BIT = 30; // Selects sub and sra

  function automatic rvga_opc rvga_opcode(rvga_word instr);
    return instr[6:0];
  endfunction

  function automatic rvga_reg rvga_rd(rvga_word instr);
    return instr[11:7];
  endfunction

  function automatic rvga_reg rvga_rs1(rvga_word instr);
    return instr[19:15];
  endfunction

  function automatic rvga_reg rvga_rs2(rvga_word instr);
    return instr[24:20];
  endfunction

  function automatic rvga_funct3 rvga_f3(rvga_word instr);
    return instr[14:12];
  endfunction

  // I-type immediate, sign extended from bit 31
  function automatic rvga_word rvga_imm_i(rvga_word instr);
    return {{20{instr[31]}}, instr[31:20]};
  endfunction

endpackage : rvga_pkg

/* hw/rvga_regfile.sv */
`timescale 1ns/1ps

module rvga_regfile
  import rvga_pkg::*;
  (
    input  logic     clk
  , input  logic     rst_i

  , input  rvga_reg  rs1_i
  , input  rvga_reg  rs2_i
  , output rvga_word data_rs1_o
  , output rvga_word data_rs2_o

  , input  logic     rd_w_v_i
  , input  rvga_reg  rd_i
  , input  rvga_word data_rd_i
  );

  rvga_word regs [32];
  rvga_word rs1_next;
  rvga_word rs2_next;
  logic     wr_en;

  always_comb begin
    wr_en = rd_w_v_i && (rd_i != '0);

    rs1_next = regs[rs1_i];
    if (wr_en && rd_i == rs1_i) rs1_next = data_rd_i; // Write-through
    if (rs1_i == '0) rs1_next = '0;

    rs2_next = regs[rs2_i];
    if (wr_en && rd_i == rs2_i) rs2_next = data_rd_i;
    if (rs2_i == '0) rs2_next = '0;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
      data_rs1_o <= '0;
      data_rs2_o <= '0;
    end else begin
      if (wr_en) regs[rd_i] <= data_rd_i;
      data_rs1_o <= rs1_next;
      data_rs2_o <= rs2_next;
    end
  end

endmodule : rvga_regfile

/* hw/rvga_rfetch_stage.sv */
`timescale 1ns/1ps

module rvga_rfetch_stage
  import rvga_pkg::*;
  (
    input  logic        clk
  , input  logic        rst_i

  , input  rvga_reg     decode_rfetch_rs1_i
  , input  rvga_reg     decode_rfetch_rs2_i
  , input  rvga_reg     decode_rfetch_rd_i
  , input  logic        decode_rfetch_rd_w_v_i
  , input  rvga_word    decode_rfetch_imm_data_i
  , input  logic        decode_rfetch_imm_v_i
  , input  rvga_artop_e decode_rfetch_artop_i
  , input  logic        decode_rfetch_alt_art_i

  , output rvga_reg     rfetch_execute_rs1_o
  , output rvga_reg     rfetch_execute_rs2_o
  , output rvga_reg     rfetch_execute_rd_o
  , output logic        rfetch_execute_rd_w_v_o
  , output rvga_word    rfetch_execute_imm_data_o
  , output logic        rfetch_execute_imm_v_o
  , output rvga_word    rfetch_execute_rs1_data_o
  , output rvga_word    rfetch_execute_rs2_data_o
  , output rvga_artop_e rfetch_execute_artop_o
  , output logic        rfetch_execute_alt_art_o

  , input  logic        writeback_rfetch_rd_w_v_i
  , input  rvga_reg     writeback_rfetch_rd_i
  , input  rvga_word    writeback_rfetch_rd_data_i
  );

  // Synchronous read lines up with the control registers below
  rvga_regfile u_regfile (
    .clk        (clk)
  , .rst_i      (rst_i)
  , .rs1_i      (decode_rfetch_rs1_i)
  , .rs2_i      (decode_rfetch_rs2_i)
  , .data_rs1_o (rfetch_execute_rs1_data_o)
  , .data_rs2_o (rfetch_execute_rs2_data_o)
  , .rd_w_v_i   (writeback_rfetch_rd_w_v_i)
  , .rd_i       (writeback_rfetch_rd_i)
  , .data_rd_i  (writeback_rfetch_rd_data_i)
  );

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rfetch_execute_rs1_o      <= '0;
      rfetch_execute_rs2_o      <= '0;
      rfetch_execute_rd_o       <= '0;
      rfetch_execute_rd_w_v_o   <= 1'b0;
      rfetch_execute_imm_data_o <= '0;
      rfetch_execute_imm_v_o    <= 1'b0;
      rfetch_execute_artop_o    <= RVGA_ARTOP_ADD;
      rfetch_execute_alt_art_o  <= 1'b0;
    end else begin
      rfetch_execute_rs1_o      <= decode_rfetch_rs1_i;
      rfetch_execute_rs2_o      <= decode_rfetch_rs2_i;
      rfetch_execute_rd_o       <= decode_rfetch_rd_i;
      rfetch_execute_rd_w_v_o   <= decode_rfetch_rd_w_v_i;
      rfetch_execute_imm_data_o <= decode_rfetch_imm_data_i;
      rfetch_execute_imm_v_o    <= decode_rfetch_imm_v_i;
      rfetch_execute_artop_o    <= decode_rfetch_artop_i;
      rfetch_execute_alt_art_o  <= decode_rfetch_alt_art_i;
    end
  end

endmodule : rvga_rfetch_stage

/* rvga_core.f */
hw/rvga_pkg.sv
hw/rvga_decode.sv
hw/rvga_regfile.sv
hw/rvga_rfetch_stage.sv
hw/rvga_execute.sv
hw/rvga_core.sv
testbench/rvga_core_tb.sv

/* testbench/rvga_core_tb.sv */
`timescale 1ns/1ps

module rvga_core_tb
  import rvga_pkg::*;
  ();

  localparam int LATENCY       = 3;  // Drive cycle to visible writeback
  localparam int DRAIN_TIMEOUT = 40;

  localparam logic [2:0] F3_ADD  = 3'd0;
  localparam logic [2:0] F3_SLL  = 3'd1;
  localparam logic [2:0] F3_SLT  = 3'd2;
  localparam logic [2:0] F3_SLTU = 3'd3;
  localparam logic [2:0] F3_XOR  = 3'd4;
  localparam logic [2:0] F3_SRL  = 3'd5;
  localparam logic [2:0] F3_OR   = 3'd6;
  localparam logic [2:0] F3_AND  = 3'd7;

  logic     clk;
  logic     rst_i;
  rvga_word instr_i;
  logic     instr_v_i;
  logic     wb_v_o;
  rvga_reg  wb_rd_o;
  rvga_word wb_data_o;

  rvga_word ref_regs [32];
  int       exp_cycle_q [$];
  rvga_reg  exp_rd_q [$];
  rvga_word exp_data_q [$];
  int       cycle = 0;
  logic     mon_en;
  logic     wb_expected;
  integer   seed;

  rvga_core u_dut (
    .clk       (clk)
  , .rst_i     (rst_i)
  , .instr_i   (instr_i)
  , .instr_v_i (instr_v_i)
  , .wb_v_o    (wb_v_o)
  , .wb_rd_o   (wb_rd_o)
  , .wb_data_o (wb_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Simulation stopped after a failed check");
  endtask

  function automatic rvga_word op_instr(logic alt, rvga_reg rs2, rvga_reg rs1,
                                        logic [2:0] f3, rvga_reg rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, RVGA_OPC_OP};
  endfunction

  function automatic rvga_word opimm_instr(logic [11:0] imm, rvga_reg rs1,
                                           logic [2:0] f3, rvga_reg rd);
    return {imm, rs1, f3, rd, RVGA_OPC_OPIMM};
  endfunction

  function automatic rvga_word shift_instr(logic alt, logic [4:0] shamt, rvga_reg rs1,
                                           logic [2:0] f3, rvga_reg rd);
    return opimm_instr({1'b0, alt, 5'b0, shamt}, rs1, f3, rd);
  endfunction

  // RV32I semantics on the model's own register state
  function automatic rvga_word ref_result(rvga_word instr);
    rvga_word a;
    rvga_word b;
    logic     is_op;
    is_op = (instr[6:0] == RVGA_OPC_OP);
    a = ref_regs[instr[19:15]];
    b = is_op ? ref_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
    case (instr[14:12])
      F3_ADD:  ref_result = (is_op && instr[30]) ? a - b : a + b;
      F3_SLL:  ref_result = a << b[4:0];
      F3_SLT:  ref_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU: ref_result = (a < b) ? 32'd1 : 32'd0;
      F3_XOR:  ref_result = a ^ b;
      F3_SRL: begin
        if (instr[30]) ref_result = rvga_word'($signed(a) >>> b[4:0]);
        else ref_result = a >> b[4:0];
      end
      F3_OR:   ref_result = a | b;
      default: ref_result = a & b;
    endcase
  endfunction

  task automatic issue(input rvga_word instr, input logic valid);
    logic     writes;
    rvga_word result;
    @(posedge clk);
    #1;
    instr_i   = instr;
    instr_v_i = valid;
    writes = valid && (instr[6:0] == RVGA_OPC_OP || instr[6:0] == RVGA_OPC_OPIMM)
             && (instr[11:7] != 5'd0);
    if (writes) begin
      result = ref_result(instr);
      ref_regs[instr[11:7]] = result;
      exp_cycle_q.push_back(cycle);
      exp_rd_q.push_back(instr[11:7]);
      exp_data_q.push_back(result);
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
      instr_v_i = 1'b0;
      instr_i   = $random(seed); // Junk on the bus while not valid
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    idle(1);
    while (exp_cycle_q.size() != 0) begin
      if (waited >= DRAIN_TIMEOUT) begin
        fail_run($sformatf("Timeout at %0t: %0d expected writebacks never arrived",
                           $time, exp_cycle_q.size()));
      end else begin
        idle(1);
        waited++;
      end
    end
    idle(LATENCY); // Trailing cycles must stay quiet too
  endtask

  always @(negedge clk) begin
    if (mon_en) begin
      wb_expected = (exp_cycle_q.size() != 0) && (exp_cycle_q[0] + LATENCY == cycle);
      assert (wb_v_o === wb_expected) else
        fail_run($sformatf("MISMATCH at %0t: wb_v_o expected %0b, got %0b",
                           $time, wb_expected, wb_v_o));
      if (wb_expected) begin
        assert (wb_rd_o === exp_rd_q[0]) else
          fail_run($sformatf("MISMATCH at %0t: wb_rd_o expected %0d, got %0d",
                             $time, exp_rd_q[0], wb_rd_o));
        assert (wb_data_o === exp_data_q[0]) else
          fail_run($sformatf("MISMATCH at %0t: wb_data_o expected 0x%08h, got 0x%08h",
                             $time, exp_data_q[0], wb_data_o));
        void'(exp_cycle_q.pop_front());
        void'(exp_rd_q.pop_front());
        void'(exp_data_q.pop_front());
      end
    end
  end

  task automatic reset_clears_regs();
    idle(5);
    issue(opimm_instr(12'h800, 5'd1, F3_ADD, 5'd1), 1'b1); // x1 was zero
    issue(opimm_instr(12'h7ff, 5'd2, F3_ADD, 5'd2), 1'b1);
    wait_drain();
  endtask

  task automatic opimm_results();
    issue(opimm_instr(12'hb2e, 5'd0, F3_ADD, 5'd1), 1'b1); // -1234
    issue(opimm_instr(12'h7ff, 5'd0, F3_ADD, 5'd2), 1'b1);
    issue(opimm_instr(12'hf9c, 5'd1, F3_ADD, 5'd3), 1'b1);
    issue(opimm_instr(12'h005, 5'd1, F3_SLT, 5'd4), 1'b1);
    issue(opimm_instr(12'hfff, 5'd2, F3_SLT, 5'd5), 1'b1);
    issue(opimm_instr(12'h005, 5'd1, F3_SLTU, 5'd6), 1'b1);
    issue(opimm_instr(12'hfff, 5'd2, F3_SLTU, 5'd7), 1'b1); // Imm reads as all ones
    issue(opimm_instr(12'hfff, 5'd1, F3_XOR, 5'd8), 1'b1);
    issue(opimm_instr(12'h800, 5'd2, F3_OR, 5'd9), 1'b1);
    issue(opimm_instr(12'hf0f, 5'd1, F3_AND, 5'd10), 1'b1);
    issue(shift_instr(1'b0, 5'd7, 5'd1, F3_SLL, 5'd11), 1'b1);
    issue(shift_instr(1'b0, 5'd4, 5'd1, F3_SRL, 5'd12), 1'b1);
    issue(shift_instr(1'b1, 5'd4, 5'd1, F3_SRL, 5'd13), 1'b1);
    issue(shift_instr(1'b1, 5'd31, 5'd2, F3_SRL, 5'd14), 1'b1);
    wait_drain();
  endtask

  task automatic op_results();
    issue(opimm_instr(12'hff9, 5'd0, F3_ADD, 5'd20), 1'b1); // -7
    issue(opimm_instr(12'h003, 5'd0, F3_ADD, 5'd21), 1'b1);
    issue(op_instr(1'b0, 5'd21, 5'd20, F3_ADD, 5'd23), 1'b1);
    issue(op_instr(1'b1, 5'd20, 5'd21, F3_ADD, 5'd24), 1'b1);
    issue(op_instr(1'b0, 5'd21, 5'd20, F3_SLL, 5'd25), 1'b1);
    issue(op_instr(1'b0, 5'd20, 5'd21, F3_SLL, 5'd16), 1'b1); // Only low five bits shift
    issue(op_instr(1'b0, 5'd21, 5'd20, F3_SLT, 5'd26), 1'b1);
    issue(op_instr(1'b0, 5'd21, 5'd20, F3_SLTU, 5'd27), 1'b1);
    issue(op_instr(1'b0, 5'd20, 5'd21, F3_SLT, 5'd18), 1'b1);
    issue(op_instr(1'b0, 5'd20, 5'd21, F3_SLTU, 5'd17), 1'b1);
    issue(op_instr(1'b0, 5'd21, 5'd20, F3_XOR, 5'd28), 1'b1);
    issue(op_instr(1'b0, 5'd21, 5'd20, F3_SRL, 5'd29), 1'b1);
    issue(op_instr(1'b1, 5'd21, 5'd20, F3_SRL, 5'd30), 1'b1);
    issue(op_instr(1'b0, 5'd21, 5'd20, F3_OR, 5'd31), 1'b1);
    issue(op_instr(1'b0, 5'd21, 5'd20, F3_AND, 5'd19), 1'b1);
    wait_drain();
  endtask

  task automatic dependent_chains();
    issue(opimm_instr(12'd100, 5'd0, F3_ADD, 5'd3), 1'b1);
    issue(opimm_instr(12'd1, 5'd3, F3_ADD, 5'd4), 1'b1);     // Distance one
    issue(op_instr(1'b0, 5'd4, 5'd3, F3_ADD, 5'd5), 1'b1);   // Two on x3, one on x4
    issue(op_instr(1'b0, 5'd5, 5'd3, F3_XOR, 5'd6), 1'b1);   // Three on x3
    issue(opimm_instr(12'd1, 5'd0, F3_ADD, 5'd7), 1'b1);
    repeat (4) issue(op_instr(1'b0, 5'd7, 5'd7, F3_ADD, 5'd7), 1'b1);
    issue(opimm_instr(12'd5, 5'd0, F3_ADD, 5'd8), 1'b1);
    issue(opimm_instr(12'd0, 5'd0, F3_ADD, 5'd9), 1'b1);
    issue(op_instr(1'b0, 5'd8, 5'd8, F3_ADD, 5'd8), 1'b1);   // Write-through path
    issue(opimm_instr(12'd9, 5'd0, F3_ADD, 5'd10), 1'b1);
    idle(1);
    issue(op_instr(1'b1, 5'd10, 5'd0, F3_ADD, 5'd10), 1'b1);
    wait_drain();
  endtask

  task automatic suppressed_writes();
    issue(opimm_instr(12'd55, 5'd0, F3_ADD, 5'd15), 1'b1);
    issue(op_instr(1'b0, 5'd15, 5'd15, F3_ADD, 5'd0), 1'b1);
    issue(op_instr(1'b0, 5'd0, 5'd0, F3_ADD, 5'd14), 1'b1);  // x0 never forwarded
    issue({20'h12345, 5'd5, 7'b0110111}, 1'b1);              // LUI is a bubble
    issue({7'd0, 5'd15, 5'd15, 3'd2, 5'd4, 7'b0100011}, 1'b1);
    issue(op_instr(1'b0, 5'd15, 5'd15, F3_ADD, 5'd5), 1'b0);
    issue(opimm_instr(12'd0, 5'd5, F3_ADD, 5'd13), 1'b1);
    issue(opimm_instr(12'd0, 5'd0, F3_ADD, 5'd12), 1'b1);
    wait_drain();
  endtask

  task automatic random_stream(input int count);
    int       rnd;
    int       sel;
    rvga_word instr;
    for (int n = 0; n < count; n++) begin
      rnd = $random(seed);
      sel = $random(seed);
      instr = rnd;
      instr[6:0] = sel[0] ? RVGA_OPC_OP : RVGA_OPC_OPIMM;
      issue(instr, 1'b1);
      if (((sel >> 1) & 7) == 0) idle(1 + ((sel >> 4) & 3));
    end
    wait_drain();
  endtask

  initial begin
    rst_i     = 1'b1;
    instr_i   = opimm_instr(12'h123, 5'd0, F3_ADD, 5'd1); // Live write held through reset
    instr_v_i = 1'b1;
    mon_en    = 1'b0;
    seed      = 32'heb03;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_i     = 1'b0;
    instr_v_i = 1'b0;
    mon_en    = 1'b1;

    reset_clears_regs();
    opimm_results();
    op_results();
    dependent_chains();
    suppressed_writes();
    random_stream(300);

    $display("No errors");
    $finish;
  end

endmodule : rvga_core_tb
